// File: filelist.f
verilog/global_buffer_pkg.sv
verilog/glb_axil_regs.sv
verilog/glb_dma_fsm.sv
verilog/glb_addr_counter.sv
verilog/glb_bank.sv
verilog/glb_tile_router.sv
verilog/global_buffer.sv
verif/tb_global_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and judges the result from sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_global_buffer -Mdir obj_dir -o tb_global_buffer > sim.log 2>&1 \
    || { echo "Verilator build failed, see sim.log"; exit 1; }

./obj_dir/tb_global_buffer >> sim.log 2>&1

grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "Simulation ended without a result, see sim.log"; exit 1; }
echo "Simulation passed"

// File: verif/tb_global_buffer.sv
`timescale 1ns/1ps

module tb_global_buffer;
    import global_buffer_pkg::*;

    localparam int NUM_TILES       = 4;
    localparam int BANK_DEPTH      = 256;
    localparam int NUM_ENTRIES     = 9;
    localparam int CLK_PERIOD      = 20;
    localparam int WATCHDOG_CYCLES = 200 * NUM_ENTRIES + 2000;

    logic       clk;
    logic       clk_en;
    logic       rst_n;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;
    cgra_word_t f2g_data [NUM_TILES];
    logic       f2g_valid [NUM_TILES];
    cgra_word_t g2f_data [NUM_TILES];
    logic       g2f_valid [NUM_TILES];
    cgra_cfg_t  cfg_in;
    cgra_cfg_t  cfg_out [NUM_TILES];
    logic       interrupt;

    logic [15:0] lfsr;
    cgra_word_t  model [BANK_DEPTH];        // What the bank should hold
    dma_cmd_t    blocks [NUM_ENTRIES];

    global_buffer #(
        .NUM_TILES  (NUM_TILES),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_global_buffer (
        .clk                   (clk),
        .clk_en                (clk_en),
        .rst_n                 (rst_n),
        .if_axil_awaddr        (awaddr),
        .if_axil_awready       (awready),
        .if_axil_awvalid       (awvalid),
        .if_axil_wdata         (wdata),
        .if_axil_wready        (wready),
        .if_axil_wvalid        (wvalid),
        .if_axil_bready        (bready),
        .if_axil_bresp         (bresp),
        .if_axil_bvalid        (bvalid),
        .if_axil_araddr        (araddr),
        .if_axil_arready       (arready),
        .if_axil_arvalid       (arvalid),
        .if_axil_rdata         (rdata),
        .if_axil_rready        (rready),
        .if_axil_rresp         (rresp),
        .if_axil_rvalid        (rvalid),
        .if_axil_wstrb         (wstrb),
        .if_axil_arprot        (3'b000),
        .if_axil_awprot        (3'b000),
        .stream_data_f2g       (f2g_data),
        .stream_data_valid_f2g (f2g_valid),
        .stream_data_g2f       (g2f_data),
        .stream_data_valid_g2f (g2f_valid),
        .cgra_cfg_gc2glb       (cfg_in),
        .cgra_cfg_g2f          (cfg_out),
        .interrupt             (interrupt)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic cgra_cfg_t random_cfg();
        cgra_cfg_t c;
        c.cfg_wr   = 1'(take_bits(1));
        c.cfg_rd   = 1'(take_bits(1));
        c.cfg_addr = take_bits(32);
        c.cfg_data = take_bits(32);
        return c;
    endfunction

    function automatic axil_addr_t bank_addr(int word);
        return BANK_BASE + axil_addr_t'(word * 4);
    endfunction

    function automatic axil_data_t ctrl_word(dma_cmd_t cmd);
        return axil_data_t'({cmd.tile, 2'b00, cmd.dir, 1'b1});     // Bit 0 starts the block
    endfunction

    task automatic check(input logic [65:0] actual, input logic [65:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output logic [1:0] resp);
        @(posedge clk);
        #2;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output logic [1:0] resp);
        @(posedge clk);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
    endtask

    task automatic write_okay(input axil_addr_t addr, input axil_data_t data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check(resp, RESP_OKAY, $sformatf("write response at 0x%0h", addr));
    endtask

    task automatic read_bank_word(input int idx);
        axil_data_t data;
        logic [1:0] resp;
        axil_read(bank_addr(idx), data, resp);
        check(resp, RESP_OKAY, "bank read response");
        check(data[15:0], model[idx], $sformatf("bank word %0d", idx));
    endtask

    task automatic reset_and_cfg_checks();
        cgra_cfg_t prev;
        cgra_cfg_t cur;
        @(negedge clk);
        check({awready, wready, bvalid, arready, rvalid, interrupt}, 0, "handshake after reset");
        for (int t = 0; t < NUM_TILES; t++) begin
            check(g2f_valid[t], 0, "stream valid after reset");
            check(cfg_out[t], 0, "configuration after reset");
        end
        prev = cfg_in;
        repeat (12) begin
            @(posedge clk);
            #2;
            cur    = random_cfg();
            cfg_in = cur;
            @(negedge clk);
            for (int t = 0; t < NUM_TILES; t++) check(cfg_out[t], prev, "configuration broadcast");
            prev = cur;
        end
        @(posedge clk);
        #2;
        clk_en = 1'b0;
        cur    = random_cfg();
        cfg_in = cur;
        repeat (5) begin
            @(negedge clk);
            for (int t = 0; t < NUM_TILES; t++) check(cfg_out[t], prev, "held with clk_en low");
        end
        @(posedge clk);
        #2;
        clk_en = 1'b1;
        @(negedge clk);
        @(negedge clk);
        for (int t = 0; t < NUM_TILES; t++) check(cfg_out[t], cur, "broadcast after clk_en");
    endtask

    task automatic bank_window_roundtrip();
        cgra_word_t w;
        for (int i = 0; i < BANK_DEPTH; i++) begin
            w        = cgra_word_t'(take_bits(16));
            model[i] = w;
            write_okay(bank_addr(i), {cgra_word_t'(take_bits(16)), w});  // Upper half dropped
        end
        for (int i = 0; i < BANK_DEPTH; i++) read_bank_word(i);
    endtask

    // Starts at the negedge where dma_start is high and wants the first word 3 cycles later
    task automatic collect_outbound(input dma_cmd_t cmd);
        int got;
        int first;
        got   = 0;
        first = -1;
        for (int n = 0; n < int'(cmd.num_words) + 10; n++) begin
            for (int t = 0; t < NUM_TILES; t++) begin
                if (g2f_valid[t] && t != int'(cmd.tile)) begin
                    check(t, cmd.tile, "stream valid on an unselected tile");
                end else if (g2f_valid[t]) begin
                    if (first < 0) first = n;
                    check(n, first + got, "gap in the outbound stream");
                    check(got < int'(cmd.num_words), 1, "extra outbound word");
                    check(g2f_data[t], model[(int'(cmd.start_addr) + got) % BANK_DEPTH],
                          $sformatf("outbound word %0d", got));
                    got++;
                end
            end
            @(negedge clk);
        end
        check(got, cmd.num_words, "number of outbound words");
        if (got > 0) check(first, 3, "cycles from start to the first word");
    endtask

    task automatic feed_inbound(input dma_cmd_t cmd);
        int         sel;
        int         decoy;
        int         gap;
        cgra_word_t w;
        sel   = int'(cmd.tile);
        decoy = (sel + 1) % NUM_TILES;
        @(posedge clk);                     // The FSM reaches ST_IN on this edge
        for (int k = 0; k < int'(cmd.num_words); k++) begin
            gap = int'(take_bits(2));
            repeat (gap) begin
                #2;
                f2g_valid[sel]   = 1'b0;
                f2g_data[decoy]  = cgra_word_t'(take_bits(16));
                f2g_valid[decoy] = 1'b1;
                @(posedge clk);
            end
            w = cgra_word_t'(take_bits(16));
            model[(int'(cmd.start_addr) + k) % BANK_DEPTH] = w;
            #2;
            f2g_data[sel]    = w;
            f2g_valid[sel]   = 1'b1;
            f2g_data[decoy]  = cgra_word_t'(take_bits(16));
            f2g_valid[decoy] = 1'b1;
            @(posedge clk);
        end
        #2;
        f2g_valid[sel]   = 1'b0;
        f2g_valid[decoy] = 1'b0;
    endtask

    task automatic finish_block();
        axil_data_t data;
        logic [1:0] resp;
        while (!interrupt) @(negedge clk);
        axil_read(REG_STATUS, data, resp);
        check(data, 32'h2, "status after the block");
        write_okay(REG_STATUS, 32'h2);
        check(interrupt, 0, "interrupt after clearing done");
    endtask

    task automatic run_block(input dma_cmd_t cmd);
        write_okay(REG_START, axil_data_t'(cmd.start_addr));
        write_okay(REG_COUNT, axil_data_t'(cmd.num_words));
        write_okay(REG_CTRL, ctrl_word(cmd));
        if (cmd.dir) begin
            feed_inbound(cmd);
            finish_block();
            // One untouched neighbour on each side
            for (int i = -1; i <= int'(cmd.num_words); i++) begin
                read_bank_word((int'(cmd.start_addr) + i + BANK_DEPTH) % BANK_DEPTH);
            end
        end else begin
            collect_outbound(cmd);
            finish_block();
        end
    endtask

    task automatic busy_refusal_checks();
        dma_cmd_t   cmd;
        axil_data_t data;
        logic [1:0] resp;
        cmd = '{1'b0, 4'd2, 16'h0080, 16'd40};
        write_okay(REG_START, axil_data_t'(cmd.start_addr));
        write_okay(REG_COUNT, axil_data_t'(cmd.num_words));
        write_okay(REG_CTRL, ctrl_word(cmd));
        fork
            collect_outbound(cmd);
            begin
                axil_read(bank_addr(5), data, resp);
                check(resp, RESP_SLVERR, "bank read while busy");
                check(data, 0, "data of a refused bank read");
                axil_write(bank_addr(5), 32'h0000_5A5A, resp);
                check(resp, RESP_SLVERR, "bank write while busy");
                write_okay(REG_CTRL, ctrl_word(cmd));
                axil_read(REG_STATUS, data, resp);
                check(data[0], 1, "busy flag during the block");
            end
        join
        finish_block();
        read_bank_word(5);
    endtask

    initial begin
        clk_en  = 1'b1;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        cfg_in  = '1;                       // Reset must clear the broadcast register
        for (int t = 0; t < NUM_TILES; t++) begin
            f2g_data[t]  = '0;
            f2g_valid[t] = 1'b0;
        end
        lfsr = 16'd73;
        // dir, tile, start, count
        blocks[0] = '{1'b0, 4'd0, 16'h0010, 16'd8};
        blocks[1] = '{1'b0, 4'd3, 16'h00F8, 16'd16};
        blocks[2] = '{1'b0, 4'd1, 16'h00FF, 16'd2};
        blocks[3] = '{1'b1, 4'd2, 16'h0040, 16'd10};
        blocks[4] = '{1'b0, 4'd2, 16'h0040, 16'd10};
        blocks[5] = '{1'b1, 4'd0, 16'h00FA, 16'd12};
        blocks[6] = '{1'b0, 4'd1, 16'h01FE, 16'd4};
        blocks[7] = '{1'b1, 4'd3, 16'h0000, 16'd5};
        blocks[8] = '{1'b0, 4'd1, 16'h0030, 16'd0};
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        reset_and_cfg_checks();
        bank_window_roundtrip();
        for (int e = 0; e < NUM_ENTRIES; e++) run_block(blocks[e]);
        busy_refusal_checks();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verilog/glb_addr_counter.sv
`timescale 1ns/1ps

module glb_addr_counter #(
    parameter int BANK_DEPTH = 256
) (
    input  logic                         clk,
    input  logic                         clk_en,
    input  logic                         rst_n,
    input  logic                         cnt_load,
    input  global_buffer_pkg::glb_addr_t load_addr,
    input  global_buffer_pkg::glb_addr_t load_count,
    input  logic                         cnt_step,
    output global_buffer_pkg::glb_addr_t cnt_addr,
    output logic                         cnt_last,
    output logic                         cnt_zero
);
    import global_buffer_pkg::*;

    localparam int AW = $clog2(BANK_DEPTH);

    logic [AW-1:0] addr_q;
    glb_addr_t     count_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q  <= '0;
            count_q <= '0;
        end else if (clk_en) begin
            if (cnt_load) begin
                addr_q  <= load_addr[AW-1:0];
                count_q <= load_count;
            end else if (cnt_step) begin
                addr_q  <= addr_q + 1'b1;               // Wraps at the bank size
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign cnt_addr = glb_addr_t'(addr_q);
    assign cnt_last = count_q == glb_addr_t'(1);
    assign cnt_zero = count_q == '0;

    a_no_step_empty: assert property (@(posedge clk) disable iff (!rst_n)
        clk_en && cnt_step && !cnt_load |-> !cnt_zero);

endmodule

// File: verilog/glb_axil_regs.sv
`timescale 1ns/1ps

module glb_axil_regs (
    input  logic                          clk,
    input  logic                          clk_en,
    input  logic                          rst_n,

    input  global_buffer_pkg::axil_addr_t awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  global_buffer_pkg::axil_data_t wdata,
    input  global_buffer_pkg::axil_strb_t wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  global_buffer_pkg::axil_addr_t araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output global_buffer_pkg::axil_data_t rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,

    output global_buffer_pkg::dma_cmd_t   dma_cmd,
    output logic                          dma_start,
    input  logic                          dma_busy,
    input  logic                          dma_done,
    output global_buffer_pkg::bank_req_t  host_req,
    input  global_buffer_pkg::cgra_word_t host_rdata,
    output logic                          interrupt
);
    import global_buffer_pkg::*;

    logic       wr_acc;
    logic       rd_acc;
    logic       wr_bank;
    logic       rd_bank;
    logic       rd_to_bank;
    logic       rd_bank_q;
    logic       done_q;
    axil_data_t reg_rdata;

    function automatic glb_addr_t merge16(glb_addr_t old, axil_data_t wd, axil_strb_t st);
        glb_addr_t res;
        res = old;
        if (st[0]) res[7:0] = wd[7:0];
        if (st[1]) res[15:8] = wd[15:8];
        return res;
    endfunction

    assign wr_bank = awaddr >= BANK_BASE;
    assign rd_bank = araddr >= BANK_BASE;
    assign wr_acc  = clk_en && awvalid && wvalid && !bvalid;
    // A bank read waits a cycle behind a bank write since the bank has one port
    assign rd_acc  = clk_en && arvalid && !rvalid && !rd_bank_q && !(wr_acc && wr_bank && rd_bank);
    assign rd_to_bank = rd_acc && rd_bank && !dma_busy;

    assign awready   = wr_acc;
    assign wready    = wr_acc;
    assign arready   = rd_acc;
    assign interrupt = done_q;

    always_comb begin
        host_req = '0;
        if (wr_acc && wr_bank && !dma_busy) begin
            host_req.en    = 1'b1;
            host_req.we    = 1'b1;
            host_req.addr  = glb_addr_t'((awaddr - BANK_BASE) >> 2);
            host_req.wdata = wdata[15:0];
        end else if (rd_to_bank) begin
            host_req.en   = 1'b1;
            host_req.addr = glb_addr_t'((araddr - BANK_BASE) >> 2);
        end
    end

    always_comb begin
        case (araddr)
            REG_CTRL:   reg_rdata = axil_data_t'({dma_cmd.tile, 2'b00, dma_cmd.dir, 1'b0});
            REG_START:  reg_rdata = axil_data_t'(dma_cmd.start_addr);
            REG_COUNT:  reg_rdata = axil_data_t'(dma_cmd.num_words);
            REG_STATUS: reg_rdata = axil_data_t'({done_q, dma_busy});
            default:    reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            rd_bank_q <= 1'b0;
            dma_start <= 1'b0;
            done_q    <= 1'b0;
            dma_cmd   <= '0;
        end else if (clk_en) begin
            dma_start <= 1'b0;
            if (bvalid && bready) bvalid <= 1'b0;
            if (rvalid && rready) rvalid <= 1'b0;
            if (dma_done) begin
                done_q <= 1'b1;
            end else if (wr_acc && awaddr == REG_STATUS && wstrb[0] && wdata[1]) begin
                done_q <= 1'b0;                         // Write one to clear
            end
            if (wr_acc) begin
                bvalid <= 1'b1;
                case (awaddr)
                    REG_CTRL: begin
                        if (wstrb[0]) begin
                            dma_cmd.dir  <= wdata[1];
                            dma_cmd.tile <= wdata[7:4];
                            dma_start    <= wdata[0] && !dma_busy;
                        end
                    end
                    REG_START: dma_cmd.start_addr <= merge16(dma_cmd.start_addr, wdata, wstrb);
                    REG_COUNT: dma_cmd.num_words  <= merge16(dma_cmd.num_words, wdata, wstrb);
                    default: ;
                endcase
            end
            rd_bank_q <= rd_to_bank;
            if ((rd_acc && !rd_to_bank) || rd_bank_q) rvalid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (wr_acc) bresp <= (wr_bank && dma_busy) ? RESP_SLVERR : RESP_OKAY;
            if (rd_acc && !rd_to_bank) begin
                rresp <= rd_bank ? RESP_SLVERR : RESP_OKAY;
                rdata <= rd_bank ? '0 : reg_rdata;      // Refused bank reads return zero
            end else if (rd_bank_q) begin
                rresp <= RESP_OKAY;
                rdata <= axil_data_t'(host_rdata);
            end
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid);
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(dma_start && dma_busy));

endmodule

// File: verilog/glb_bank.sv
`timescale 1ns/1ps

module glb_bank #(
    parameter int BANK_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          clk_en,
    input  global_buffer_pkg::bank_req_t  host_req,
    input  global_buffer_pkg::bank_req_t  dma_req,
    output global_buffer_pkg::cgra_word_t host_rdata,
    output global_buffer_pkg::cgra_word_t dma_rdata
);
    import global_buffer_pkg::*;

    localparam int AW = $clog2(BANK_DEPTH);

    cgra_word_t    mem [BANK_DEPTH];
    bank_req_t     req;
    logic [AW-1:0] idx;
    cgra_word_t    rdata_q;
    logic          grant_dma_q;

    assign req = dma_req.en ? dma_req : host_req;   // DMA always wins
    assign idx = req.addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (req.en) begin
                if (req.we) begin
                    mem[idx] <= req.wdata;
                end else begin
                    rdata_q <= mem[idx];
                end
            end
            grant_dma_q <= dma_req.en;
        end
    end

    // Read data goes back only to the side that asked for it
    assign dma_rdata  = grant_dma_q ? rdata_q : '0;
    assign host_rdata = grant_dma_q ? '0 : rdata_q;

    a_one_requester: assert property (@(posedge clk)
        clk_en |-> !(host_req.en && dma_req.en));

endmodule

// File: verilog/glb_dma_fsm.sv
`timescale 1ns/1ps

module glb_dma_fsm #(
    parameter int NUM_TILES = 4
) (
    input  logic                          clk,
    input  logic                          clk_en,
    input  logic                          rst_n,
    input  global_buffer_pkg::dma_cmd_t   dma_cmd,
    input  logic                          dma_start,
    output logic                          dma_busy,
    output logic                          dma_done,
    output logic                          cnt_load,
    output logic                          cnt_step,
    input  global_buffer_pkg::glb_addr_t  cnt_addr,
    input  logic                          cnt_last,
    input  logic                          cnt_zero,
    output global_buffer_pkg::bank_req_t  dma_req,
    input  global_buffer_pkg::cgra_word_t dma_rdata,
    output global_buffer_pkg::cgra_word_t out_word,
    output logic                          out_valid,
    output global_buffer_pkg::tile_id_t   out_tile,
    output global_buffer_pkg::tile_id_t   in_tile,
    input  global_buffer_pkg::cgra_word_t in_word,
    input  logic                          in_valid
);
    import global_buffer_pkg::*;

    glb_state_e state;
    glb_state_e state_nxt;
    tile_id_t   tile_q;
    logic       rd_pend;

    always_comb begin
        state_nxt     = state;
        cnt_load      = 1'b0;
        cnt_step      = 1'b0;
        dma_req       = '0;
        dma_req.addr  = cnt_addr;
        dma_req.wdata = in_word;
        case (state)
            ST_IDLE: begin
                if (dma_start) begin
                    if (int'(dma_cmd.tile) >= NUM_TILES) begin
                        state_nxt = ST_DONE;            // No such tile so nothing moves
                    end else begin
                        cnt_load  = 1'b1;
                        state_nxt = dma_cmd.dir ? ST_IN : ST_OUT;
                    end
                end
            end
            ST_OUT: begin
                if (cnt_zero) begin
                    state_nxt = ST_DONE;
                end else begin
                    dma_req.en = 1'b1;
                    cnt_step   = 1'b1;
                    if (cnt_last) state_nxt = ST_DONE;
                end
            end
            ST_IN: begin
                if (cnt_zero) begin
                    state_nxt = ST_DONE;
                end else if (in_valid) begin
                    dma_req.en = 1'b1;
                    dma_req.we = 1'b1;
                    cnt_step   = 1'b1;
                    if (cnt_last) state_nxt = ST_DONE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            rd_pend <= 1'b0;
            tile_q  <= '0;
        end else if (clk_en) begin
            state   <= state_nxt;
            rd_pend <= dma_req.en && !dma_req.we;       // Bank data shows up next cycle
            if (state == ST_IDLE && dma_start) tile_q <= dma_cmd.tile;
        end
    end

    assign dma_busy  = state != ST_IDLE;
    assign dma_done  = state == ST_DONE;
    assign out_word  = dma_rdata;
    assign out_valid = rd_pend;
    assign out_tile  = tile_q;
    assign in_tile   = tile_q;

    a_start_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        dma_start |-> state == ST_IDLE);

endmodule

// File: verilog/glb_tile_router.sv
`timescale 1ns/1ps

module glb_tile_router #(
    parameter int NUM_TILES = 4
) (
    input  logic                          clk,
    input  logic                          clk_en,
    input  logic                          rst_n,
    input  global_buffer_pkg::cgra_word_t out_word,
    input  logic                          out_valid,
    input  global_buffer_pkg::tile_id_t   out_tile,
    output global_buffer_pkg::cgra_word_t stream_data_g2f [NUM_TILES],
    output logic                          stream_data_valid_g2f [NUM_TILES],
    input  global_buffer_pkg::tile_id_t   in_tile,
    input  global_buffer_pkg::cgra_word_t stream_data_f2g [NUM_TILES],
    input  logic                          stream_data_valid_f2g [NUM_TILES],
    output global_buffer_pkg::cgra_word_t in_word,
    output logic                          in_valid,
    input  global_buffer_pkg::cgra_cfg_t  cgra_cfg_gc2glb,
    output global_buffer_pkg::cgra_cfg_t  cgra_cfg_g2f [NUM_TILES]
);
    import global_buffer_pkg::*;

    cgra_cfg_t cfg_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (clk_en) begin
            cfg_q <= cgra_cfg_gc2glb;
        end
    end

    for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
        logic sel;

        assign sel = out_tile == tile_id_t'(i);

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                stream_data_valid_g2f[i] <= 1'b0;
            end else if (clk_en) begin
                stream_data_valid_g2f[i] <= out_valid && sel;
            end
        end

        always_ff @(posedge clk) begin
            if (clk_en && out_valid && sel) stream_data_g2f[i] <= out_word;
        end

        assign cgra_cfg_g2f[i] = cfg_q;             // Same word to every tile
    end

    always_comb begin
        in_word  = '0;
        in_valid = 1'b0;
        for (int i = 0; i < NUM_TILES; i++) begin
            if (in_tile == tile_id_t'(i)) begin
                in_word  = stream_data_f2g[i];
                in_valid = stream_data_valid_f2g[i];
            end
        end
    end

endmodule

// File: verilog/global_buffer.sv
`timescale 1ns/1ps

module global_buffer #(
    parameter int NUM_TILES  = 4,
    parameter int BANK_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          clk_en,
    input  logic                          rst_n,

    input  global_buffer_pkg::axil_addr_t if_axil_awaddr,
    output logic                          if_axil_awready,
    input  logic                          if_axil_awvalid,
    input  global_buffer_pkg::axil_data_t if_axil_wdata,
    output logic                          if_axil_wready,
    input  logic                          if_axil_wvalid,
    input  logic                          if_axil_bready,
    output logic [1:0]                    if_axil_bresp,
    output logic                          if_axil_bvalid,
    input  global_buffer_pkg::axil_addr_t if_axil_araddr,
    output logic                          if_axil_arready,
    input  logic                          if_axil_arvalid,
    output global_buffer_pkg::axil_data_t if_axil_rdata,
    input  logic                          if_axil_rready,
    output logic [1:0]                    if_axil_rresp,
    output logic                          if_axil_rvalid,
    input  global_buffer_pkg::axil_strb_t if_axil_wstrb,
    input  logic [2:0]                    if_axil_arprot,   // Protection bits have no effect
    input  logic [2:0]                    if_axil_awprot,

    input  global_buffer_pkg::cgra_word_t stream_data_f2g [NUM_TILES],
    input  logic                          stream_data_valid_f2g [NUM_TILES],
    output global_buffer_pkg::cgra_word_t stream_data_g2f [NUM_TILES],
    output logic                          stream_data_valid_g2f [NUM_TILES],
    input  global_buffer_pkg::cgra_cfg_t  cgra_cfg_gc2glb,
    output global_buffer_pkg::cgra_cfg_t  cgra_cfg_g2f [NUM_TILES],
    output logic                          interrupt
);
    import global_buffer_pkg::*;

    dma_cmd_t   dma_cmd;
    logic       dma_start;
    logic       dma_busy;
    logic       dma_done;
    bank_req_t  host_req;
    bank_req_t  dma_req;
    cgra_word_t host_rdata;
    cgra_word_t dma_rdata;
    logic       cnt_load;
    logic       cnt_step;
    logic       cnt_last;
    logic       cnt_zero;
    glb_addr_t  cnt_addr;
    cgra_word_t out_word;
    logic       out_valid;
    tile_id_t   out_tile;
    cgra_word_t in_word;
    logic       in_valid;
    tile_id_t   in_tile;

    glb_axil_regs u_glb_axil_regs (
        .awaddr  (if_axil_awaddr),
        .awvalid (if_axil_awvalid),
        .awready (if_axil_awready),
        .wdata   (if_axil_wdata),
        .wstrb   (if_axil_wstrb),
        .wvalid  (if_axil_wvalid),
        .wready  (if_axil_wready),
        .bresp   (if_axil_bresp),
        .bvalid  (if_axil_bvalid),
        .bready  (if_axil_bready),
        .araddr  (if_axil_araddr),
        .arvalid (if_axil_arvalid),
        .arready (if_axil_arready),
        .rdata   (if_axil_rdata),
        .rresp   (if_axil_rresp),
        .rvalid  (if_axil_rvalid),
        .rready  (if_axil_rready),
        .*
    );

    glb_dma_fsm #(.NUM_TILES(NUM_TILES)) u_glb_dma_fsm (.*);

    glb_addr_counter #(.BANK_DEPTH(BANK_DEPTH)) u_glb_addr_counter (
        .load_addr  (dma_cmd.start_addr),
        .load_count (dma_cmd.num_words),
        .*
    );

    glb_bank #(.BANK_DEPTH(BANK_DEPTH)) u_glb_bank (.*);

    glb_tile_router #(.NUM_TILES(NUM_TILES)) u_glb_tile_router (.*);

endmodule

// File: verilog/global_buffer_pkg.sv
package global_buffer_pkg;

    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [15:0] cgra_word_t;
    typedef logic [15:0] glb_addr_t;
    typedef logic [3:0]  tile_id_t;

    typedef struct packed {
        logic        cfg_wr;
        logic        cfg_rd;
        logic [31:0] cfg_addr;
        logic [31:0] cfg_data;
    } cgra_cfg_t;

    typedef struct packed {
        logic      dir;         // 0 sends bank words to a tile, 1 collects from a tile
        tile_id_t  tile;
        glb_addr_t start_addr;
        glb_addr_t num_words;
    } dma_cmd_t;

    typedef struct packed {
        logic       en;
        logic       we;
        glb_addr_t  addr;
        cgra_word_t wdata;
    } bank_req_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_OUT,
        ST_IN,
        ST_DONE
    } glb_state_e;

    localparam axil_addr_t REG_CTRL   = 12'h000;
    localparam axil_addr_t REG_START  = 12'h004;
    localparam axil_addr_t REG_COUNT  = 12'h008;
    localparam axil_addr_t REG_STATUS = 12'h00C;
    localparam axil_addr_t BANK_BASE  = 12'h800;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
